// ==== testbench/dcasic_stim.txt ====
# All values hex. W addr data | R addr data err | L mode nbytes bytes (0 none 1 raw 2 pooled)
# F nbytes (pattern line) | V vsync pulse | E dcx byte | I cycles
W 00000000 a5a50001
W 00000004 0badcafe
W 000003fc 12345678
R 00000000 a5a50001 0
R 00000006 0badcafe 0
R 000003ff 12345678 0
R 60000000 00000000 1
R e0000000 00000000 1
W 40000000 00000007
R 40000000 00000007 0
W 40000000 00000001
V
V
V
R 40000004 00000003 0
W 20000000 00000001
R 20000000 00000001 0
E 0 2c
W 21000000 0000002c
E 0 3a
W 21000000 0000003a
I 8
W 20000000 00000003
R 20000000 00000003 0
L 1 10 00 01 ff fe 5a a5 3c c3 80 7f 12 ed 01 02 03 04
I 20
W 40000000 00000005
L 2 a 12 34 56 78 9a bc de f0 11 22
I 10
L 2 8 f8 00 07 e0 00 1f 84 10
I 20
W 20000000 00000001
W 40000000 00000001
F 4a
R 40000008 00000001 0

// ==== flist.f ====
+incdir+testbench
rtl/dcasic_pkg.sv
rtl/cfg_decoder.sv
rtl/instr_mem.sv
rtl/dvp_rx.sv
rtl/max_pool_h.sv
rtl/pixel_fifo.sv
rtl/dbi_tx.sv
rtl/dcasic.sv
testbench/tb_dcasic.sv

// ==== Bender.yml ====
package:
  name: dcasic

sources:
  - files:
      - rtl/dcasic_pkg.sv
      - rtl/cfg_decoder.sv
      - rtl/instr_mem.sv
      - rtl/dvp_rx.sv
      - rtl/max_pool_h.sv
      - rtl/pixel_fifo.sv
      - rtl/dbi_tx.sv
      - rtl/dcasic.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_dcasic.sv

// ==== testbench/tb_dcasic_checks.svh ====
`ifndef TB_DCASIC_CHECKS_SVH
`define TB_DCASIC_CHECKS_SVH

// Ends the run at the first failure
task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
endtask

// Configuration read data and error flag
task automatic check_cfg(input string name, input cfg_data_t exp_data, input logic exp_err,
                         input cfg_data_t act_data, input logic act_err);
    if (act_data !== exp_data || act_err !== exp_err) begin
        $display("** Error %s: expected data %h err %b, actual data %h err %b",
                 name, exp_data, exp_err, act_data, act_err);
        abort_run();
    end
endtask

// One DBI byte as seen on rising wrx
task automatic check_dbi(input string name, input logic exp_dcx, input dbi_byte_t exp_byte,
                         input logic act_dcx, input dbi_byte_t act_byte);
    if (act_dcx !== exp_dcx || act_byte !== exp_byte) begin
        $display("** Error %s: expected dcx %b byte %h, actual dcx %b byte %h",
                 name, exp_dcx, exp_byte, act_dcx, act_byte);
        abort_run();
    end
endtask

// Single control or status line
task automatic check_pin(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
        $display("** Error %s: expected %b, actual %b", name, exp_val, act_val);
        abort_run();
    end
endtask

`endif

// ==== testbench/tb_dcasic.sv ====
`timescale 1ns/1ps
module tb_dcasic;
    import dcasic_pkg::*;

    `include "tb_dcasic_checks.svh"

    localparam string STIM_FILE      = "testbench/dcasic_stim.txt";
    localparam int    CYCLES_PER_OP  = 64;

    logic      sys_clk = 1'b0;
    logic      reset_i;
    logic      cfg_wr;
    logic      cfg_rd;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;
    dbi_byte_t dvp_d;
    logic      dvp_href;
    logic      dvp_vsync;
    logic      rd_valid;
    cfg_data_t rd_data;
    logic      rd_err;
    logic      dvp_pwdn;
    logic      dbi_dcx, dbi_csx, dbi_resx, dbi_rdx, dbi_wrx;
    dbi_byte_t dbi_d;

    logic [8:0]  exp_dbi [$];   // {dcx, byte}
    logic [8:0]  exp_item;
    dbi_byte_t   line_q [$];
    int          dbi_count = 0;
    int unsigned wd_cycles = 0;

    dcasic dcasic_i (
        .sys_clk(sys_clk), .reset_i(reset_i),
        .cfg_wr_i(cfg_wr), .cfg_rd_i(cfg_rd), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
        .rd_valid_o(rd_valid), .rd_data_o(rd_data), .rd_err_o(rd_err),
        .dvp_d_i(dvp_d), .dvp_href_i(dvp_href), .dvp_vsync_i(dvp_vsync),
        .dvp_pwdn_o(dvp_pwdn),
        .dbi_dcx_o(dbi_dcx), .dbi_csx_o(dbi_csx), .dbi_resx_o(dbi_resx),
        .dbi_rdx_o(dbi_rdx), .dbi_wrx_o(dbi_wrx), .dbi_d_o(dbi_d)
    );

    always #20 sys_clk = ~sys_clk;

    // RGB565 field-wise maximum of two pixels
    function automatic logic [15:0] max_rgb565(input logic [15:0] a, input logic [15:0] b);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] bl;
        r  = (a[15:11] > b[15:11]) ? a[15:11] : b[15:11];
        g  = (a[10:5] > b[10:5]) ? a[10:5] : b[10:5];
        bl = (a[4:0] > b[4:0]) ? a[4:0] : b[4:0];
        return {r, g, bl};
    endfunction

    task automatic need_fields(input int got, input int want, input logic [7:0] op);
        if (got != want) begin
            $display("Stim line for operation %c has %0d fields, %0d needed", op, got, want);
            abort_run();
        end
    endtask

    task automatic idle_gap();
        repeat ($urandom % 4) @(posedge sys_clk);
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
        @(posedge sys_clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge sys_clk);
        cfg_wr    <= 1'b0;
        if (addr[31:29] == CAM_ID && addr[3:2] == 2'd0) begin
            @(negedge sys_clk);
            check_pin("camera pwdn follows control", data[1], dvp_pwdn);
        end
        if (addr[31:24] == 8'h20) begin
            @(negedge sys_clk);
            check_pin("display resx follows control", data[0], dbi_resx);
        end
    endtask

    task automatic cfg_read(input cfg_addr_t addr, input cfg_data_t exp_data, input logic exp_err);
        string name;
        name = $sformatf("read %h", addr);
        @(posedge sys_clk);
        cfg_rd   <= 1'b1;
        cfg_addr <= addr;
        @(posedge sys_clk);
        cfg_rd   <= 1'b0;
        @(negedge sys_clk);   // Data valid right after the strobe edge
        check_pin({name, " valid"}, 1'b1, rd_valid);
        check_cfg(name, exp_data, exp_err, rd_data, rd_err);
        @(negedge sys_clk);
        check_pin({name, " valid one cycle"}, 1'b0, rd_valid);
    endtask

    // Mode 0 expects nothing, 1 raw pixels, 2 pooled pairs
    task automatic play_line(input int mode);
        int          npix;
        int          p;
        logic [15:0] pm;
        npix = line_q.size() / 2;
        if (mode == 1) begin
            foreach (line_q[k]) exp_dbi.push_back({1'b1, line_q[k]});
        end
        if (mode == 2) begin
            for (p = 0; p + 1 < npix; p += 2) begin
                pm = max_rgb565({line_q[2*p], line_q[2*p+1]}, {line_q[2*p+2], line_q[2*p+3]});
                exp_dbi.push_back({1'b1, pm[15:8]});
                exp_dbi.push_back({1'b1, pm[7:0]});
            end
        end
        foreach (line_q[k]) begin
            @(posedge sys_clk);
            dvp_href <= 1'b1;
            dvp_d    <= line_q[k];
        end
        @(posedge sys_clk);
        dvp_href <= 1'b0;
        dvp_d    <= '0;
    endtask

    task automatic vsync_pulse();
        @(posedge sys_clk);
        dvp_vsync <= 1'b1;
        repeat (2) @(posedge sys_clk);
        dvp_vsync <= 1'b0;
    endtask

    // Display side, samples on the rising write strobe
    always @(posedge dbi_wrx) begin
        if (!reset_i) begin
            if (exp_dbi.size() == 0) begin
                $display("DBI byte %h with dcx %b appeared when none was expected", dbi_d, dbi_dcx);
                abort_run();
            end else begin
                check_pin("dbi csx during write strobe", 1'b0, dbi_csx);
                exp_item = exp_dbi.pop_front();
                check_dbi($sformatf("dbi byte %0d", dbi_count), exp_item[8], exp_item[7:0],
                          dbi_dcx, dbi_d);
                dbi_count++;
            end
        end
    end

    initial begin : watchdog
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge sys_clk);
        $display("Timeout: stimulus did not finish within %0d cycles", wd_cycles);
        abort_run();
    end

    initial begin : player
        int          fd;
        int          rc;
        int          n_lines;
        int          mode;
        int          count;
        string       text;
        logic [7:0]  op;
        cfg_addr_t   addr;
        cfg_data_t   data;
        logic        err;
        logic        dcx;
        dbi_byte_t   b;
        int unsigned seed;
        seed      = $urandom(32'hc44a_ca33);
        reset_i   = 1'b1;
        cfg_wr    = 1'b0;
        cfg_rd    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        dvp_d     = '0;
        dvp_href  = 1'b0;
        dvp_vsync = 1'b0;
        n_lines   = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stim file %s", STIM_FILE);
            abort_run();
        end
        while ($fgets(text, fd) > 0) n_lines++;
        $fclose(fd);
        wd_cycles = n_lines * CYCLES_PER_OP;
        fd = $fopen(STIM_FILE, "r");

        repeat (3) @(posedge sys_clk);
        reset_i <= 1'b0;
        @(negedge sys_clk);
        check_pin("reset csx", 1'b1, dbi_csx);
        check_pin("reset wrx", 1'b1, dbi_wrx);
        check_pin("reset rdx", 1'b1, dbi_rdx);
        check_pin("reset dcx", 1'b1, dbi_dcx);
        check_pin("reset resx", 1'b0, dbi_resx);
        check_pin("reset pwdn", 1'b1, dvp_pwdn);
        check_pin("reset rd_valid", 1'b0, rd_valid);

        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": rc = $fgets(text, fd);
                "W": begin
                    rc = $fscanf(fd, "%h %h", addr, data);
                    need_fields(rc, 2, op);
                    idle_gap();
                    cfg_write(addr, data);
                end
                "R": begin
                    rc = $fscanf(fd, "%h %h %h", addr, data, err);
                    need_fields(rc, 3, op);
                    idle_gap();
                    cfg_read(addr, data, err);
                end
                "L": begin
                    rc = $fscanf(fd, "%h %h", mode, count);
                    need_fields(rc, 2, op);
                    line_q.delete();
                    repeat (count) begin
                        rc = $fscanf(fd, "%h", b);
                        need_fields(rc, 1, op);
                        line_q.push_back(b);
                    end
                    idle_gap();
                    play_line(mode);
                end
                "F": begin
                    rc = $fscanf(fd, "%h", count);
                    need_fields(rc, 1, op);
                    line_q.delete();
                    for (int k = 0; k < count; k++) line_q.push_back(dbi_byte_t'(k) ^ 8'h5a);
                    idle_gap();
                    play_line(0);
                end
                "V": begin
                    idle_gap();
                    vsync_pulse();
                end
                "E": begin
                    rc = $fscanf(fd, "%h %h", dcx, b);
                    need_fields(rc, 2, op);
                    exp_dbi.push_back({dcx, b});
                end
                "I": begin
                    rc = $fscanf(fd, "%h", count);
                    need_fields(rc, 1, op);
                    repeat (count) @(posedge sys_clk);
                end
                default: begin
                    $display("Unknown stim operation %c", op);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);

        repeat (8) @(posedge sys_clk);
        if (exp_dbi.size() != 0) begin
            $display("%0d expected DBI bytes never appeared", exp_dbi.size());
            abort_run();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== rtl/dcasic.sv ====
`timescale 1ns/1ps
module dcasic (
    input  logic                  sys_clk,
    input  logic                  reset_i,
    // Configuration bus
    input  logic                  cfg_wr_i,
    input  logic                  cfg_rd_i,
    input  dcasic_pkg::cfg_addr_t cfg_addr_i,
    input  dcasic_pkg::cfg_data_t cfg_wdata_i,
    output logic                  rd_valid_o,
    output dcasic_pkg::cfg_data_t rd_data_o,
    output logic                  rd_err_o,
    // Camera
    input  dcasic_pkg::dbi_byte_t dvp_d_i,
    input  logic                  dvp_href_i,
    input  logic                  dvp_vsync_i,
    output logic                  dvp_pwdn_o,
    // Display
    output logic                  dbi_dcx_o,
    output logic                  dbi_csx_o,
    output logic                  dbi_resx_o,
    output logic                  dbi_rdx_o,
    output logic                  dbi_wrx_o,
    output dcasic_pkg::dbi_byte_t dbi_d_o
);
    import dcasic_pkg::*;

    logic      imem_wr, imem_rd, dsp_wr, dsp_rd, cam_wr, cam_rd;
    cfg_data_t imem_rdata, dsp_rdata, cam_rdata;
    logic      pool_en, overflow;
    logic      cam_pix_valid, pool_pix_valid;
    pixel_u    cam_pix, pool_pix, fifo_pix;
    logic      fifo_empty, pop;

    assign dbi_rdx_o = 1'b1;   // Write-only master

    cfg_decoder dec (
        .sys_clk(sys_clk), .reset_i(reset_i),
        .cfg_wr_i(cfg_wr_i), .cfg_rd_i(cfg_rd_i), .cfg_addr_i(cfg_addr_i),
        .imem_rdata_i(imem_rdata), .dsp_rdata_i(dsp_rdata), .cam_rdata_i(cam_rdata),
        .imem_wr_o(imem_wr), .imem_rd_o(imem_rd),
        .dsp_wr_o(dsp_wr), .dsp_rd_o(dsp_rd),
        .cam_wr_o(cam_wr), .cam_rd_o(cam_rd),
        .rd_valid_o(rd_valid_o), .rd_data_o(rd_data_o), .rd_err_o(rd_err_o)
    );

    instr_mem im (
        .sys_clk(sys_clk), .wr_i(imem_wr), .rd_i(imem_rd),
        .addr_i(cfg_addr_i), .wdata_i(cfg_wdata_i), .rdata_o(imem_rdata)
    );

    dvp_rx crc (
        .sys_clk(sys_clk), .reset_i(reset_i),
        .wr_i(cam_wr), .rd_i(cam_rd), .addr_i(cfg_addr_i), .wdata_i(cfg_wdata_i),
        .overflow_i(overflow),
        .dvp_d_i(dvp_d_i), .dvp_href_i(dvp_href_i), .dvp_vsync_i(dvp_vsync_i),
        .rdata_o(cam_rdata), .dvp_pwdn_o(dvp_pwdn_o), .pool_en_o(pool_en),
        .pix_valid_o(cam_pix_valid), .pix_o(cam_pix)
    );

    max_pool_h pool (
        .sys_clk(sys_clk), .reset_i(reset_i),
        .pool_en_i(pool_en), .line_i(dvp_href_i),
        .pix_valid_i(cam_pix_valid), .pix_i(cam_pix),
        .pix_valid_o(pool_pix_valid), .pix_o(pool_pix)
    );

    pixel_fifo fifo (
        .sys_clk(sys_clk), .reset_i(reset_i),
        .push_i(pool_pix_valid), .push_pix_i(pool_pix), .pop_i(pop),
        .pop_pix_o(fifo_pix), .empty_o(fifo_empty), .overflow_o(overflow)
    );

    dbi_tx dtc (
        .sys_clk(sys_clk), .reset_i(reset_i),
        .wr_i(dsp_wr), .rd_i(dsp_rd), .addr_i(cfg_addr_i), .wdata_i(cfg_wdata_i),
        .fifo_empty_i(fifo_empty), .pix_i(fifo_pix),
        .rdata_o(dsp_rdata), .pop_o(pop),
        .dbi_dcx_o(dbi_dcx_o), .dbi_csx_o(dbi_csx_o), .dbi_resx_o(dbi_resx_o),
        .dbi_wrx_o(dbi_wrx_o), .dbi_d_o(dbi_d_o)
    );

endmodule

// ==== rtl/dbi_tx.sv ====
`timescale 1ns/1ps
module dbi_tx (
    input  logic                  sys_clk,
    input  logic                  reset_i,
    input  logic                  wr_i,
    input  logic                  rd_i,
    input  dcasic_pkg::cfg_addr_t addr_i,
    input  dcasic_pkg::cfg_data_t wdata_i,
    input  logic                  fifo_empty_i,
    input  dcasic_pkg::pixel_u    pix_i,
    output dcasic_pkg::cfg_data_t rdata_o,
    output logic                  pop_o,
    output logic                  dbi_dcx_o,
    output logic                  dbi_csx_o,
    output logic                  dbi_resx_o,
    output logic                  dbi_wrx_o,
    output dcasic_pkg::dbi_byte_t dbi_d_o
);
    import dcasic_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,   // wrx low
        ST_LATCH     // wrx high, display samples
    } tx_state_e;

    tx_state_e state;
    logic      stream_en;
    logic      cmd_pending;
    dbi_byte_t cmd_q;
    dbi_byte_t pix_lo_q;
    logic      second_q;
    logic      can_start;
    logic      take_cmd;
    logic      take_pix;

    // Next byte may start when nothing is left of the current item
    assign can_start = (state == ST_IDLE) || (state == ST_LATCH && !second_q);
    assign take_cmd  = can_start && cmd_pending;
    assign take_pix  = can_start && !cmd_pending && stream_en && dbi_resx_o && !fifo_empty_i;
    assign pop_o     = take_pix;

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            dbi_resx_o  <= 1'b0;   // Display held in reset
            stream_en   <= 1'b0;
            cmd_pending <= 1'b0;
            state       <= ST_IDLE;
            second_q    <= 1'b0;
            dbi_csx_o   <= 1'b1;
            dbi_wrx_o   <= 1'b1;
            dbi_dcx_o   <= 1'b1;
            dbi_d_o     <= '0;
        end else begin
            if (wr_i && !addr_i[DSP_TX_SEL_BIT]) begin
                {stream_en, dbi_resx_o} <= wdata_i[1:0];
            end
            if (wr_i && addr_i[DSP_TX_SEL_BIT] && !cmd_pending) begin
                cmd_q       <= wdata_i[7:0];
                cmd_pending <= 1'b1;
            end else if (take_cmd) begin
                cmd_pending <= 1'b0;
            end

            if (take_cmd) begin
                dbi_dcx_o <= 1'b0;
                dbi_d_o   <= cmd_q;
                dbi_csx_o <= 1'b0;
                dbi_wrx_o <= 1'b0;
                state     <= ST_STROBE;
            end else if (take_pix) begin
                dbi_dcx_o <= 1'b1;
                dbi_d_o   <= pix_i.bytes.hi;   // High byte first
                pix_lo_q  <= pix_i.bytes.lo;
                second_q  <= 1'b1;
                dbi_csx_o <= 1'b0;
                dbi_wrx_o <= 1'b0;
                state     <= ST_STROBE;
            end else begin
                case (state)
                    ST_STROBE: begin
                        dbi_wrx_o <= 1'b1;
                        state     <= ST_LATCH;
                    end
                    ST_LATCH: begin
                        if (second_q) begin
                            dbi_d_o   <= pix_lo_q;
                            dbi_wrx_o <= 1'b0;
                            second_q  <= 1'b0;
                            state     <= ST_STROBE;
                        end else begin
                            dbi_csx_o <= 1'b1;
                            state     <= ST_IDLE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rd_i) rdata_o <= cfg_data_t'({cmd_pending, stream_en, dbi_resx_o});
    end

    // Write strobe only inside a chip select
    assert property (@(posedge sys_clk) disable iff (reset_i) !dbi_wrx_o |-> !dbi_csx_o);

endmodule

// ==== rtl/pixel_fifo.sv ====
`timescale 1ns/1ps
module pixel_fifo (
    input  logic               sys_clk,
    input  logic               reset_i,
    input  logic               push_i,
    input  dcasic_pkg::pixel_u push_pix_i,
    input  logic               pop_i,
    output dcasic_pkg::pixel_u pop_pix_o,
    output logic               empty_o,
    output logic               overflow_o
);
    import dcasic_pkg::*;

    pixel_u               mem [PIX_FIFO_DEPTH];
    logic [PIX_PTR_W-1:0] wr_ptr;
    logic [PIX_PTR_W-1:0] rd_ptr;
    pix_cnt_t             count;
    logic                 full;
    logic                 push_ok;

    assign empty_o   = (count == '0);
    assign full      = (count == pix_cnt_t'(PIX_FIFO_DEPTH));
    assign push_ok   = push_i && !full;
    assign pop_pix_o = mem[rd_ptr];    // Show-ahead

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= push_i && full;   // Pixel lost
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;
            if (pop_i)   rd_ptr <= rd_ptr + 1'b1;
            count <= count + pix_cnt_t'(push_ok) - pix_cnt_t'(pop_i);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (push_ok) mem[wr_ptr] <= push_pix_i;
    end

    assert property (@(posedge sys_clk) disable iff (reset_i) pop_i |-> !empty_o);

endmodule

// ==== rtl/max_pool_h.sv ====
`timescale 1ns/1ps
module max_pool_h (
    input  logic               sys_clk,
    input  logic               reset_i,
    input  logic               pool_en_i,
    input  logic               line_i,
    input  logic               pix_valid_i,
    input  dcasic_pkg::pixel_u pix_i,
    output logic               pix_valid_o,
    output dcasic_pkg::pixel_u pix_o
);
    import dcasic_pkg::*;

    logic   have_first;
    pixel_u first_q;
    pixel_u pooled;

    // Per-channel maximum of the pair
    always_comb begin
        pooled.rgb.r = (first_q.rgb.r > pix_i.rgb.r) ? first_q.rgb.r : pix_i.rgb.r;
        pooled.rgb.g = (first_q.rgb.g > pix_i.rgb.g) ? first_q.rgb.g : pix_i.rgb.g;
        pooled.rgb.b = (first_q.rgb.b > pix_i.rgb.b) ? first_q.rgb.b : pix_i.rgb.b;
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            pix_valid_o <= 1'b0;
            have_first  <= 1'b0;
        end else if (!pool_en_i) begin
            pix_valid_o <= pix_valid_i;
            have_first  <= 1'b0;
        end else if (pix_valid_i) begin
            pix_valid_o <= have_first;
            have_first  <= !have_first;
        end else begin
            pix_valid_o <= 1'b0;
            if (!line_i) have_first <= 1'b0;   // Odd last pixel dropped
        end
    end

    always_ff @(posedge sys_clk) begin
        if (pix_valid_i && !have_first) first_q <= pix_i;
        if (pix_valid_i) pix_o <= pool_en_i ? pooled : pix_i;
    end

endmodule

// ==== rtl/dvp_rx.sv ====
`timescale 1ns/1ps
module dvp_rx (
    input  logic                  sys_clk,
    input  logic                  reset_i,
    input  logic                  wr_i,
    input  logic                  rd_i,
    input  dcasic_pkg::cfg_addr_t addr_i,
    input  dcasic_pkg::cfg_data_t wdata_i,
    input  logic                  overflow_i,
    input  dcasic_pkg::dbi_byte_t dvp_d_i,
    input  logic                  dvp_href_i,
    input  logic                  dvp_vsync_i,
    output dcasic_pkg::cfg_data_t rdata_o,
    output logic                  dvp_pwdn_o,
    output logic                  pool_en_o,
    output logic                  pix_valid_o,
    output dcasic_pkg::pixel_u    pix_o
);
    import dcasic_pkg::*;

    logic                  cap_en;
    logic                  overflow_q;
    logic                  vsync_q;
    logic                  second_byte;
    logic                  byte_en;
    logic [CAM_REG_AW-1:0] reg_ofs;
    cfg_data_t             frame_cnt;

    assign reg_ofs = addr_i[CAM_REG_AW+1:2];
    assign byte_en = dvp_href_i && !dvp_vsync_i && cap_en;

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            cap_en      <= 1'b0;
            dvp_pwdn_o  <= 1'b1;   // Camera powered down
            pool_en_o   <= 1'b0;
            overflow_q  <= 1'b0;
            vsync_q     <= 1'b0;
            frame_cnt   <= '0;
            second_byte <= 1'b0;
            pix_valid_o <= 1'b0;
        end else begin
            if (wr_i && reg_ofs == CAM_CTRL_OFS) begin
                {pool_en_o, dvp_pwdn_o, cap_en} <= wdata_i[2:0];
            end
            if (overflow_i) begin
                overflow_q <= 1'b1;
            end
            vsync_q <= dvp_vsync_i;
            if (cap_en && dvp_vsync_i && !vsync_q) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            // Phase restarts on href low or vsync
            second_byte <= byte_en && !second_byte;
            pix_valid_o <= byte_en && second_byte;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (byte_en) begin
            if (second_byte) pix_o.bytes.lo <= dvp_d_i;
            else             pix_o.bytes.hi <= dvp_d_i;
        end
        if (rd_i) begin
            case (reg_ofs)
                CAM_CTRL_OFS: rdata_o <= cfg_data_t'({pool_en_o, dvp_pwdn_o, cap_en});
                CAM_FCNT_OFS: rdata_o <= frame_cnt;
                CAM_STAT_OFS: rdata_o <= cfg_data_t'(overflow_q);
                default:      rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== rtl/instr_mem.sv ====
`timescale 1ns/1ps
module instr_mem (
    input  logic                  sys_clk,
    input  logic                  wr_i,
    input  logic                  rd_i,
    input  dcasic_pkg::cfg_addr_t addr_i,
    input  dcasic_pkg::cfg_data_t wdata_i,
    output dcasic_pkg::cfg_data_t rdata_o
);
    import dcasic_pkg::*;

    cfg_data_t          mem [2**IMEM_AW];
    logic [IMEM_AW-1:0] word_idx;

    // Byte address to word index
    assign word_idx = addr_i[IMEM_AW+1:2];

    always_ff @(posedge sys_clk) begin
        if (wr_i) begin
            mem[word_idx] <= wdata_i;
        end
        if (rd_i) begin
            rdata_o <= mem[word_idx];   // One cycle latency
        end
    end

endmodule

// ==== rtl/cfg_decoder.sv ====
`timescale 1ns/1ps
module cfg_decoder (
    input  logic                  sys_clk,
    input  logic                  reset_i,
    input  logic                  cfg_wr_i,
    input  logic                  cfg_rd_i,
    input  dcasic_pkg::cfg_addr_t cfg_addr_i,
    input  dcasic_pkg::cfg_data_t imem_rdata_i,
    input  dcasic_pkg::cfg_data_t dsp_rdata_i,
    input  dcasic_pkg::cfg_data_t cam_rdata_i,
    output logic                  imem_wr_o,
    output logic                  imem_rd_o,
    output logic                  dsp_wr_o,
    output logic                  dsp_rd_o,
    output logic                  cam_wr_o,
    output logic                  cam_rd_o,
    output logic                  rd_valid_o,
    output dcasic_pkg::cfg_data_t rd_data_o,
    output logic                  rd_err_o
);
    import dcasic_pkg::*;

    slv_id_t slv_id;
    slv_id_t rd_id_q;   // Slave of the read in flight

    assign slv_id = cfg_addr_i[$bits(cfg_addr_t)-1 -: $bits(slv_id_t)];

    assign imem_wr_o = cfg_wr_i && (slv_id == IMEM_ID);
    assign imem_rd_o = cfg_rd_i && (slv_id == IMEM_ID);
    assign dsp_wr_o  = cfg_wr_i && (slv_id == DSP_ID);
    assign dsp_rd_o  = cfg_rd_i && (slv_id == DSP_ID);
    assign cam_wr_o  = cfg_wr_i && (slv_id == CAM_ID);
    assign cam_rd_o  = cfg_rd_i && (slv_id == CAM_ID);

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            rd_valid_o <= 1'b0;
            rd_id_q    <= IMEM_ID;
        end else begin
            rd_valid_o <= cfg_rd_i;
            if (cfg_rd_i) begin
                rd_id_q <= slv_id;
            end
        end
    end

    always_comb begin
        rd_data_o = '0;
        rd_err_o  = 1'b0;
        case (rd_id_q)
            IMEM_ID: rd_data_o = imem_rdata_i;
            DSP_ID:  rd_data_o = dsp_rdata_i;
            CAM_ID:  rd_data_o = cam_rdata_i;
            default: rd_err_o  = rd_valid_o;   // Unmapped, zero data
        endcase
    end

    // One slave access per cycle, never a read and a write together
    assert property (@(posedge sys_clk) disable iff (reset_i)
        $onehot0({imem_wr_o, dsp_wr_o, cam_wr_o, imem_rd_o, dsp_rd_o, cam_rd_o}));

endmodule

// ==== rtl/dcasic_pkg.sv ====
package dcasic_pkg;

    // Configuration bus
    typedef logic [31:0] cfg_addr_t;
    typedef logic [31:0] cfg_data_t;
    typedef logic [2:0]  slv_id_t;     // Top address bits

    localparam slv_id_t IMEM_ID = 3'd0;  // 0x0000_0000
    localparam slv_id_t DSP_ID  = 3'd1;  // 0x2000_0000
    localparam slv_id_t CAM_ID  = 3'd2;  // 0x4000_0000

    // Display command window at 0x2100_0000
    localparam int DSP_TX_SEL_BIT = 24;

    localparam int IMEM_AW = 8;        // 256 words

    // Camera registers, word offsets
    localparam int CAM_REG_AW = 2;
    localparam logic [CAM_REG_AW-1:0] CAM_CTRL_OFS = 2'd0;
    localparam logic [CAM_REG_AW-1:0] CAM_FCNT_OFS = 2'd1;
    localparam logic [CAM_REG_AW-1:0] CAM_STAT_OFS = 2'd2;

    typedef logic [7:0] dbi_byte_t;

    typedef struct packed {
        dbi_byte_t hi;
        dbi_byte_t lo;
    } pixel_bytes_t;

    // RGB565
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel_rgb_t;

    typedef union packed {
        pixel_bytes_t bytes;
        pixel_rgb_t   rgb;
    } pixel_u;

    localparam int PIX_FIFO_DEPTH = 16;
    localparam int PIX_PTR_W      = $clog2(PIX_FIFO_DEPTH);
    typedef logic [PIX_PTR_W:0] pix_cnt_t;  // 0 to DEPTH

endpackage
